// ==== hdl/id_config.svh ====
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define ALUOP_W    5
`define ALUSEL_W   3

// Major opcodes
`define OP_EXE    7'b0110011
`define OP_EXEI   7'b0010011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000  // SUB and SRA

// ALU funct3, shared by R and I forms
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define EX_NOP   5'd0
`define EX_ADD   5'd1
`define EX_SUB   5'd2
`define EX_XOR   5'd3
`define EX_OR    5'd4
`define EX_AND   5'd5
`define EX_SLL   5'd6
`define EX_SRL   5'd7
`define EX_SRA   5'd8
`define EX_SLT   5'd9
`define EX_SLTU  5'd10
`define EX_LB    5'd11
`define EX_LH    5'd12
`define EX_LW    5'd13
`define EX_LBU   5'd14
`define EX_LHU   5'd15
`define EX_SB    5'd16
`define EX_SH    5'd17
`define EX_SW    5'd18
`define EX_BEQ   5'd19
`define EX_BNE   5'd20
`define EX_BLT   5'd21
`define EX_BGE   5'd22
`define EX_BLTU  5'd23
`define EX_BGEU  5'd24
`define EX_JAL   5'd25
`define EX_JALR  5'd26
`define EX_AUIPC 5'd27

`define EX_RES_NOP   3'd0
`define EX_RES_ARITH 3'd1
`define EX_RES_LOGIC 3'd2
`define EX_RES_SHIFT 3'd3
`define EX_RES_LD_ST 3'd4
`define EX_RES_JAL   3'd5

`define IMM_NONE  3'd0
`define IMM_I     3'd1
`define IMM_SHAMT 3'd2
`define IMM_S     3'd3
`define IMM_B     3'd4
`define IMM_U     3'd5
`define IMM_J     3'd6

`endif

// ==== hdl/rv_inst_pkg.sv ====
`include "id_config.svh"

package rv_inst_pkg;

    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } r_fmt;
        struct packed {
            logic [11:0]            imm_11_0;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } i_fmt;
        struct packed {
            logic [6:0]             imm_11_5;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [4:0]             imm_4_0;
            logic [6:0]             opcode;
        } s_fmt;
        struct packed {
            logic                   imm_12;
            logic [5:0]             imm_10_5;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [3:0]             imm_4_1;
            logic                   imm_11;
            logic [6:0]             opcode;
        } b_fmt;
        struct packed {
            logic [19:0]            imm_31_12;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } u_fmt;
        struct packed {
            logic                   imm_20;
            logic [9:0]             imm_10_1;
            logic                   imm_11;
            logic [7:0]             imm_19_12;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } j_fmt;
    } inst_t;

endpackage

// ==== hdl/inst_decoder.sv ====
`include "id_config.svh"

module inst_decoder
    import rv_inst_pkg::*;
(
    input  inst_t                inst,
    output logic                 r1_read_enable,
    output logic                 r2_read_enable,
    output logic                 rd_enable,
    output logic                 use_imm,
    output logic [2:0]           imm_fmt,
    output logic [`ALUOP_W-1:0]  aluop,
    output logic [`ALUSEL_W-1:0] alusel
);

    always_comb begin
        r1_read_enable = 1'b0;
        r2_read_enable = 1'b0;
        rd_enable = 1'b0;
        use_imm = 1'b0;
        imm_fmt = `IMM_NONE;
        aluop = `EX_NOP;
        alusel = `EX_RES_NOP;
        case (inst.r_fmt.opcode)
            `OP_EXE: begin
                case (inst.r_fmt.funct7)
                    `F7_BASE: begin
                        case (inst.r_fmt.funct3)
                            `F3_ADD:  {aluop, alusel} = {`EX_ADD, `EX_RES_ARITH};
                            `F3_SLL:  {aluop, alusel} = {`EX_SLL, `EX_RES_SHIFT};
                            `F3_SLT:  {aluop, alusel} = {`EX_SLT, `EX_RES_ARITH};
                            `F3_SLTU: {aluop, alusel} = {`EX_SLTU, `EX_RES_ARITH};
                            `F3_XOR:  {aluop, alusel} = {`EX_XOR, `EX_RES_LOGIC};
                            `F3_SRL:  {aluop, alusel} = {`EX_SRL, `EX_RES_SHIFT};
                            `F3_OR:   {aluop, alusel} = {`EX_OR, `EX_RES_LOGIC};
                            `F3_AND:  {aluop, alusel} = {`EX_AND, `EX_RES_LOGIC};
                            default: ;
                        endcase
                    end
                    `F7_ALT: begin
                        case (inst.r_fmt.funct3)
                            `F3_ADD: {aluop, alusel} = {`EX_SUB, `EX_RES_ARITH};
                            `F3_SRL: {aluop, alusel} = {`EX_SRA, `EX_RES_SHIFT};
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
                if (aluop != `EX_NOP) begin
                    {rd_enable, r1_read_enable, r2_read_enable} = 3'b111;
                end
            end
            `OP_EXEI: begin
                case (inst.r_fmt.funct3)
                    `F3_ADD:  {aluop, alusel} = {`EX_ADD, `EX_RES_ARITH};
                    `F3_SLL:  {aluop, alusel} = {`EX_SLL, `EX_RES_SHIFT};
                    `F3_SLT:  {aluop, alusel} = {`EX_SLT, `EX_RES_ARITH};
                    `F3_SLTU: {aluop, alusel} = {`EX_SLTU, `EX_RES_ARITH};
                    `F3_XOR:  {aluop, alusel} = {`EX_XOR, `EX_RES_LOGIC};
                    `F3_OR:   {aluop, alusel} = {`EX_OR, `EX_RES_LOGIC};
                    `F3_AND:  {aluop, alusel} = {`EX_AND, `EX_RES_LOGIC};
                    `F3_SRL: begin
                        case (inst.r_fmt.funct7)
                            `F7_BASE: {aluop, alusel} = {`EX_SRL, `EX_RES_SHIFT};
                            `F7_ALT:  {aluop, alusel} = {`EX_SRA, `EX_RES_SHIFT};
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
                if (aluop != `EX_NOP) begin
                    {rd_enable, r1_read_enable, use_imm} = 3'b111;
                    imm_fmt = (alusel == `EX_RES_SHIFT) ? `IMM_SHAMT : `IMM_I;
                end
            end
            `OP_LUI: begin
                {rd_enable, use_imm} = 2'b11;
                {aluop, alusel} = {`EX_OR, `EX_RES_LOGIC};  // 0 | imm
                imm_fmt = `IMM_U;
            end
            `OP_AUIPC: begin
                rd_enable = 1'b1;
                {aluop, alusel} = {`EX_AUIPC, `EX_RES_ARITH};
                imm_fmt = `IMM_U;
            end
            `OP_LOAD: begin
                case (inst.r_fmt.funct3)
                    3'b000:  aluop = `EX_LB;
                    3'b001:  aluop = `EX_LH;
                    3'b010:  aluop = `EX_LW;
                    3'b100:  aluop = `EX_LBU;
                    3'b101:  aluop = `EX_LHU;
                    default: ;
                endcase
                if (aluop != `EX_NOP) begin
                    {rd_enable, r1_read_enable} = 2'b11;
                    alusel = `EX_RES_LD_ST;
                    imm_fmt = `IMM_I;
                end
            end
            `OP_STORE: begin
                case (inst.r_fmt.funct3)
                    3'b000:  aluop = `EX_SB;
                    3'b001:  aluop = `EX_SH;
                    3'b010:  aluop = `EX_SW;
                    default: ;
                endcase
                if (aluop != `EX_NOP) begin
                    {r1_read_enable, r2_read_enable} = 2'b11;  // Base and store data
                    alusel = `EX_RES_LD_ST;
                    imm_fmt = `IMM_S;
                end
            end
            `OP_BRANCH: begin
                case (inst.r_fmt.funct3)
                    3'b000:  aluop = `EX_BEQ;
                    3'b001:  aluop = `EX_BNE;
                    3'b100:  aluop = `EX_BLT;
                    3'b101:  aluop = `EX_BGE;
                    3'b110:  aluop = `EX_BLTU;
                    3'b111:  aluop = `EX_BGEU;
                    default: ;
                endcase
                if (aluop != `EX_NOP) begin
                    {r1_read_enable, r2_read_enable} = 2'b11;
                    imm_fmt = `IMM_B;  // No result so alusel stays NOP
                end
            end
            `OP_JAL: begin
                rd_enable = 1'b1;
                {aluop, alusel} = {`EX_JAL, `EX_RES_JAL};
                imm_fmt = `IMM_J;
            end
            `OP_JALR: begin
                {rd_enable, r1_read_enable} = 2'b11;
                {aluop, alusel} = {`EX_JALR, `EX_RES_JAL};
                imm_fmt = `IMM_I;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/imm_gen.sv ====
`include "id_config.svh"

module imm_gen
    import rv_inst_pkg::*;
(
    input  inst_t             inst,
    input  logic [2:0]        imm_fmt,
    output logic [`XLEN-1:0]  imm
);

    always_comb begin
        case (imm_fmt)
            `IMM_NONE: imm = '0;
            `IMM_I: begin
                imm = {{(`XLEN-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            end
            `IMM_SHAMT: imm = {{(`XLEN-5){1'b0}}, inst.i_fmt.imm_11_0[4:0]};
            `IMM_S: begin
                imm = {{(`XLEN-12){inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                       inst.s_fmt.imm_4_0};
            end
            `IMM_B: begin
                imm = {{(`XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};  // Halfword aligned
            end
            `IMM_U: imm = {inst.u_fmt.imm_31_12, 12'h000};
            `IMM_J: begin
                imm = {{(`XLEN-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== hdl/operand_forward.sv ====
`include "id_config.svh"

module operand_forward (
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic                   read_enable,
    input  logic [`XLEN-1:0]       rf_data,
    input  logic                   ex_wb_flag,
    input  logic                   ld_flag,
    input  logic [`REG_ADDR_W-1:0] ex_wb_addr,
    input  logic [`XLEN-1:0]       ex_forward,
    input  logic                   mem_wb_flag,
    input  logic [`REG_ADDR_W-1:0] mem_wb_addr,
    input  logic [`XLEN-1:0]       mem_forward,
    output logic [`XLEN-1:0]       operand,
    output logic                   hazard
);

    always_comb begin
        hazard = 1'b0;
        if (!read_enable || rs_addr == '0) begin
            operand = '0;  // x0 or unused
        end else if (ld_flag && ex_wb_addr == rs_addr) begin
            operand = '0;  // Load data not ready yet
            hazard = 1'b1;
        end else if (ex_wb_flag && ex_wb_addr == rs_addr) begin
            operand = ex_forward;
        end else if (mem_wb_flag && mem_wb_addr == rs_addr) begin
            operand = mem_forward;
        end else begin
            operand = rf_data;
        end
    end

endmodule

// ==== hdl/id_ex_reg.sv ====
`include "id_config.svh"

module id_ex_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic                 rd_en_d,
    input  logic                 use_imm,
    input  logic [`ALUOP_W-1:0]  aluop_d,
    input  logic [`ALUSEL_W-1:0] alusel_d,
    input  logic [`XLEN-1:0]     op1,
    input  logic [`XLEN-1:0]     op2,
    input  logic [`XLEN-1:0]     imm_d,
    output logic [`XLEN-1:0]     pc_o,
    output logic [`XLEN-1:0]     r1,
    output logic [`XLEN-1:0]     r2,
    output logic [`XLEN-1:0]     imm,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic                 rd_enable,
    output logic [`ALUOP_W-1:0]  aluop,
    output logic [`ALUSEL_W-1:0] alusel
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o <= '0;
            rd <= '0;
            r1 <= '0;
            r2 <= '0;
            imm <= '0;
            rd_enable <= 1'b0;
            aluop <= `EX_NOP;
            alusel <= `EX_RES_NOP;
        end else begin
            pc_o <= pc;
            rd <= rd_addr;
            if (stall) begin  // Bubble toward EX
                r1 <= '0;
                r2 <= '0;
                imm <= '0;
                rd_enable <= 1'b0;
                aluop <= `EX_NOP;
                alusel <= `EX_RES_NOP;
            end else begin
                r1 <= op1;
                r2 <= use_imm ? imm_d : op2;
                imm <= imm_d;
                rd_enable <= rd_en_d;
                aluop <= aluop_d;
                alusel <= alusel_d;
            end
        end
    end

    // Fetch presents the stalled instruction again
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(pc) && $stable(rd_addr));

endmodule

// ==== hdl/id_stage.sv ====
`include "id_config.svh"

module id_stage
    import rv_inst_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       pc,
    input  inst_t                  inst,
    input  logic [`XLEN-1:0]       r1_data,
    input  logic [`XLEN-1:0]       r2_data,
    input  logic                   ld_flag,
    input  logic                   ex_wb_flag,
    input  logic [`REG_ADDR_W-1:0] ex_wb_addr,
    input  logic [`XLEN-1:0]       ex_forward,
    input  logic                   mem_wb_flag,
    input  logic [`REG_ADDR_W-1:0] mem_wb_addr,
    input  logic [`XLEN-1:0]       mem_forward,
    output logic [`REG_ADDR_W-1:0] r1_addr,
    output logic                   r1_read_enable,
    output logic [`REG_ADDR_W-1:0] r2_addr,
    output logic                   r2_read_enable,
    output logic [`XLEN-1:0]       pc_o,
    output logic [`XLEN-1:0]       r1,
    output logic [`XLEN-1:0]       r2,
    output logic [`XLEN-1:0]       imm,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic                   rd_enable,
    output logic [`ALUOP_W-1:0]    aluop,
    output logic [`ALUSEL_W-1:0]   alusel,
    output logic                   id_stall
);

    logic                 dec_rd_enable;
    logic                 use_imm;
    logic [2:0]           imm_fmt;
    logic [`ALUOP_W-1:0]  dec_aluop;
    logic [`ALUSEL_W-1:0] dec_alusel;
    logic [`XLEN-1:0]     imm_val;
    logic [`XLEN-1:0]     op1;
    logic [`XLEN-1:0]     op2;
    logic                 r1_hazard;
    logic                 r2_hazard;
    wire                  stall = r1_hazard | r2_hazard;

    assign r1_addr = inst.r_fmt.rs1;
    assign r2_addr = inst.r_fmt.rs2;
    assign id_stall = stall;  // Holds fetch on load-use

    inst_decoder u_dec (
        .inst(inst), .r1_read_enable(r1_read_enable), .r2_read_enable(r2_read_enable),
        .rd_enable(dec_rd_enable), .use_imm(use_imm), .imm_fmt(imm_fmt),
        .aluop(dec_aluop), .alusel(dec_alusel)
    );

    imm_gen u_imm (.inst(inst), .imm_fmt(imm_fmt), .imm(imm_val));

    operand_forward u_fwd1 (
        .rs_addr(r1_addr), .read_enable(r1_read_enable), .rf_data(r1_data),
        .ex_wb_flag(ex_wb_flag), .ld_flag(ld_flag), .ex_wb_addr(ex_wb_addr),
        .ex_forward(ex_forward), .mem_wb_flag(mem_wb_flag), .mem_wb_addr(mem_wb_addr),
        .mem_forward(mem_forward), .operand(op1), .hazard(r1_hazard)
    );

    operand_forward u_fwd2 (
        .rs_addr(r2_addr), .read_enable(r2_read_enable), .rf_data(r2_data),
        .ex_wb_flag(ex_wb_flag), .ld_flag(ld_flag), .ex_wb_addr(ex_wb_addr),
        .ex_forward(ex_forward), .mem_wb_flag(mem_wb_flag), .mem_wb_addr(mem_wb_addr),
        .mem_forward(mem_forward), .operand(op2), .hazard(r2_hazard)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .rst(rst), .stall(stall), .pc(pc), .rd_addr(inst.r_fmt.rd),
        .rd_en_d(dec_rd_enable), .use_imm(use_imm), .aluop_d(dec_aluop),
        .alusel_d(dec_alusel), .op1(op1), .op2(op2), .imm_d(imm_val),
        .pc_o(pc_o), .r1(r1), .r2(r2), .imm(imm), .rd(rd), .rd_enable(rd_enable),
        .aluop(aluop), .alusel(alusel)
    );

endmodule

// ==== tb/tb_id_stage.sv ====
`include "id_config.svh"

module tb_id_stage;

    localparam int TEST_CYCLES = 300;
    localparam int NUM_TESTS = 6;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES = NUM_TESTS * TEST_CYCLES + 200;  // Tests plus margin

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       pc;
    logic [31:0]            inst;
    logic [`XLEN-1:0]       r1_data;
    logic [`XLEN-1:0]       r2_data;
    logic                   ld_flag;
    logic                   ex_wb_flag;
    logic [`REG_ADDR_W-1:0] ex_wb_addr;
    logic [`XLEN-1:0]       ex_forward;
    logic                   mem_wb_flag;
    logic [`REG_ADDR_W-1:0] mem_wb_addr;
    logic [`XLEN-1:0]       mem_forward;
    logic [`REG_ADDR_W-1:0] r1_addr;
    logic                   r1_read_enable;
    logic [`REG_ADDR_W-1:0] r2_addr;
    logic                   r2_read_enable;
    logic [`XLEN-1:0]       pc_o;
    logic [`XLEN-1:0]       r1;
    logic [`XLEN-1:0]       r2;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_enable;
    logic [`ALUOP_W-1:0]    aluop;
    logic [`ALUSEL_W-1:0]   alusel;
    logic                   id_stall;

    integer seed;
    int     cycles = 0;
    int     errors;
    int     test_errors;
    int     tests_failed;
    string  cur_test;
    logic   hold;        // Fetch repeats inst and pc
    logic   pred_valid;

    // Model decode of the current inst
    logic                 m_re1;
    logic                 m_re2;
    logic                 m_rd_en;
    logic                 m_use_imm;
    logic [`ALUOP_W-1:0]  m_aluop;
    logic [`ALUSEL_W-1:0] m_alusel;
    logic [`XLEN-1:0]     m_imm;

    // Expected ID/EX contents after the next edge
    logic [`XLEN-1:0]       p_pc;
    logic [`XLEN-1:0]       p_r1;
    logic [`XLEN-1:0]       p_r2;
    logic [`XLEN-1:0]       p_imm;
    logic [`REG_ADDR_W-1:0] p_rd;
    logic                   p_rd_en;
    logic [`ALUOP_W-1:0]    p_aluop;
    logic [`ALUSEL_W-1:0]   p_alusel;

    id_stage uut (
        .clk(clk), .rst(rst), .pc(pc), .inst(inst), .r1_data(r1_data), .r2_data(r2_data),
        .ld_flag(ld_flag), .ex_wb_flag(ex_wb_flag), .ex_wb_addr(ex_wb_addr),
        .ex_forward(ex_forward), .mem_wb_flag(mem_wb_flag), .mem_wb_addr(mem_wb_addr),
        .mem_forward(mem_forward), .r1_addr(r1_addr), .r1_read_enable(r1_read_enable),
        .r2_addr(r2_addr), .r2_read_enable(r2_read_enable), .pc_o(pc_o), .r1(r1), .r2(r2),
        .imm(imm), .rd(rd), .rd_enable(rd_enable), .aluop(aluop), .alusel(alusel),
        .id_stall(id_stall)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic legal_opcode(input logic [6:0] op);
        legal_opcode = op inside {`OP_EXE, `OP_EXEI, `OP_LUI, `OP_AUIPC, `OP_LOAD,
                                  `OP_STORE, `OP_BRANCH, `OP_JAL, `OP_JALR};
    endfunction

    // Mode 0 ALU, 1 memory and control, 2 any legal, 3 unknown opcode
    function automatic logic [31:0] gen_inst(input int mode);
        logic [31:0] w;
        logic [6:0]  op;
        logic        alt;
        int          m;
        int          k;
        w = $random(seed);
        m = (mode == 2) ? rand_below(2) : mode;
        k = rand_below(7);
        alt = rand_below(2) == 0;
        case (m)
            0: begin
                w[6:0] = (rand_below(2) == 0) ? `OP_EXE : `OP_EXEI;
                if (w[6:0] == `OP_EXE || w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
                    w[31:25] = 7'h00;
                    if (alt && (w[14:12] == 3'd5 || (w[14:12] == 3'd0 && w[6:0] == `OP_EXE))) begin
                        w[31:25] = 7'h20;
                    end
                end
            end
            1: begin
                case (k)
                    0: begin
                        w[6:0] = `OP_LOAD;
                        k = rand_below(5);
                        w[14:12] = (k > 2) ? 3'(k + 1) : 3'(k);  // Skip 3
                    end
                    1: begin
                        w[6:0] = `OP_STORE;
                        w[14:12] = 3'(rand_below(3));
                    end
                    2: begin
                        w[6:0] = `OP_BRANCH;
                        k = rand_below(6);
                        w[14:12] = (k > 1) ? 3'(k + 2) : 3'(k);  // Skip 2 and 3
                    end
                    3: w[6:0] = `OP_LUI;
                    4: w[6:0] = `OP_AUIPC;
                    5: w[6:0] = `OP_JAL;
                    default: begin
                        w[6:0] = `OP_JALR;
                        w[14:12] = 3'd0;
                    end
                endcase
            end
            default: begin
                do begin
                    op = 7'($random(seed));
                end while (legal_opcode(op));
                w[6:0] = op;
            end
        endcase
        gen_inst = w;
    endfunction

    function automatic logic [`ALUOP_W-1:0] alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: alu_code = alt ? `EX_SUB : `EX_ADD;
            3'd1: alu_code = `EX_SLL;
            3'd2: alu_code = `EX_SLT;
            3'd3: alu_code = `EX_SLTU;
            3'd4: alu_code = `EX_XOR;
            3'd5: alu_code = alt ? `EX_SRA : `EX_SRL;
            3'd6: alu_code = `EX_OR;
            default: alu_code = `EX_AND;
        endcase
    endfunction

    function automatic logic [`ALUSEL_W-1:0] alu_class(input logic [`ALUOP_W-1:0] op);
        if (op == `EX_SLL || op == `EX_SRL || op == `EX_SRA) begin
            alu_class = `EX_RES_SHIFT;
        end else if (op == `EX_XOR || op == `EX_OR || op == `EX_AND) begin
            alu_class = `EX_RES_LOGIC;
        end else begin
            alu_class = `EX_RES_ARITH;
        end
    endfunction

    // RV32I decode table and immediate rules
    function automatic void model_decode(input logic [31:0] w);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] i_imm;
        logic [31:0] u_imm;
        f7 = w[31:25];
        f3 = w[14:12];
        i_imm = {{20{w[31]}}, w[31:20]};
        u_imm = {w[31:12], 12'h000};
        m_re1 = 1'b0;
        m_re2 = 1'b0;
        m_rd_en = 1'b0;
        m_use_imm = 1'b0;
        m_aluop = `EX_NOP;
        m_alusel = `EX_RES_NOP;
        m_imm = '0;
        case (w[6:0])
            `OP_EXE: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                m_aluop = alu_code(f3, f7[5]);
                m_alusel = alu_class(m_aluop);
                {m_re1, m_re2, m_rd_en} = 3'b111;
            end
            `OP_EXEI: if (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20) begin
                m_aluop = alu_code(f3, f3 == 3'd5 && f7[5]);
                m_alusel = alu_class(m_aluop);
                {m_re1, m_rd_en, m_use_imm} = 3'b111;
                m_imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : i_imm;
            end
            `OP_LUI: begin
                {m_rd_en, m_use_imm} = 2'b11;
                m_aluop = `EX_OR;
                m_alusel = `EX_RES_LOGIC;
                m_imm = u_imm;
            end
            `OP_AUIPC: begin
                m_rd_en = 1'b1;
                m_aluop = `EX_AUIPC;
                m_alusel = `EX_RES_ARITH;
                m_imm = u_imm;
            end
            `OP_LOAD: begin
                case (f3)
                    3'd0: m_aluop = `EX_LB;
                    3'd1: m_aluop = `EX_LH;
                    3'd2: m_aluop = `EX_LW;
                    3'd4: m_aluop = `EX_LBU;
                    3'd5: m_aluop = `EX_LHU;
                    default: m_aluop = `EX_NOP;
                endcase
                if (m_aluop != `EX_NOP) begin
                    {m_re1, m_rd_en} = 2'b11;
                    m_alusel = `EX_RES_LD_ST;
                    m_imm = i_imm;
                end
            end
            `OP_STORE: begin
                case (f3)
                    3'd0: m_aluop = `EX_SB;
                    3'd1: m_aluop = `EX_SH;
                    3'd2: m_aluop = `EX_SW;
                    default: m_aluop = `EX_NOP;
                endcase
                if (m_aluop != `EX_NOP) begin
                    {m_re1, m_re2} = 2'b11;
                    m_alusel = `EX_RES_LD_ST;
                    m_imm = {{20{w[31]}}, w[31:25], w[11:7]};
                end
            end
            `OP_BRANCH: begin
                case (f3)
                    3'd0: m_aluop = `EX_BEQ;
                    3'd1: m_aluop = `EX_BNE;
                    3'd4: m_aluop = `EX_BLT;
                    3'd5: m_aluop = `EX_BGE;
                    3'd6: m_aluop = `EX_BLTU;
                    3'd7: m_aluop = `EX_BGEU;
                    default: m_aluop = `EX_NOP;
                endcase
                if (m_aluop != `EX_NOP) begin
                    {m_re1, m_re2} = 2'b11;
                    m_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            `OP_JAL: begin
                m_rd_en = 1'b1;
                m_aluop = `EX_JAL;
                m_alusel = `EX_RES_JAL;
                m_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OP_JALR: begin
                {m_re1, m_rd_en} = 2'b11;
                m_aluop = `EX_JALR;
                m_alusel = `EX_RES_JAL;
                m_imm = i_imm;
            end
            default: ;
        endcase
    endfunction

    function automatic logic load_use(input logic [4:0] a, input logic re);
        load_use = re && a != 5'd0 && ld_flag && ex_wb_addr == a;
    endfunction

    function automatic logic [31:0] forwarded(input logic [4:0] a, input logic re,
                                              input logic [31:0] rf);
        if (!re || a == 5'd0 || (ld_flag && ex_wb_addr == a)) begin
            forwarded = '0;
        end else if (ex_wb_flag && ex_wb_addr == a) begin
            forwarded = ex_forward;
        end else if (mem_wb_flag && mem_wb_addr == a) begin
            forwarded = mem_forward;
        end else begin
            forwarded = rf;
        end
    endfunction

    // Half the time hit rs1 or rs2 of the new instruction
    function automatic logic [4:0] pick_addr(input logic [31:0] w);
        case (rand_below(4))
            0: pick_addr = w[19:15];
            1: pick_addr = w[24:20];
            default: pick_addr = 5'($random(seed));
        endcase
    endfunction

    task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", cur_test, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic drive_inputs(input int mode, input int ld_pct);
        logic [31:0] w;
        logic [31:0] next_pc;
        if (hold) begin
            w = inst;
            next_pc = pc;
        end else begin
            w = gen_inst(mode);
            next_pc = pc + 32'd4;
        end
        inst <= w;
        pc <= next_pc;
        r1_data <= $random(seed);
        r2_data <= $random(seed);
        ex_forward <= $random(seed);
        mem_forward <= $random(seed);
        ld_flag <= rand_below(100) < ld_pct;
        ex_wb_flag <= rand_below(2) == 0;
        mem_wb_flag <= rand_below(2) == 0;
        ex_wb_addr <= pick_addr(w);
        mem_wb_addr <= pick_addr(w);
    endtask

    task automatic check_outputs();
        logic        hz;
        logic [31:0] op1;
        logic [31:0] op2;
        if (pred_valid) begin
            compare("pc_o", p_pc, pc_o);
            compare("r1", p_r1, r1);
            compare("r2", p_r2, r2);
            compare("imm", p_imm, imm);
            compare("rd", 32'(p_rd), 32'(rd));
            compare("rd_enable", 32'(p_rd_en), 32'(rd_enable));
            compare("aluop", 32'(p_aluop), 32'(aluop));
            compare("alusel", 32'(p_alusel), 32'(alusel));
        end
        model_decode(inst);
        hz = load_use(inst[19:15], m_re1) | load_use(inst[24:20], m_re2);
        op1 = forwarded(inst[19:15], m_re1, r1_data);
        op2 = forwarded(inst[24:20], m_re2, r2_data);
        compare("id_stall", 32'(hz), 32'(id_stall));
        compare("r1_read_enable", 32'(m_re1), 32'(r1_read_enable));
        compare("r2_read_enable", 32'(m_re2), 32'(r2_read_enable));
        compare("r1_addr", 32'(inst[19:15]), 32'(r1_addr));
        compare("r2_addr", 32'(inst[24:20]), 32'(r2_addr));
        p_pc = pc;
        p_rd = inst[11:7];
        p_r1 = hz ? '0 : op1;
        p_r2 = hz ? '0 : (m_use_imm ? m_imm : op2);
        p_imm = hz ? '0 : m_imm;
        p_rd_en = hz ? 1'b0 : m_rd_en;
        p_aluop = hz ? `EX_NOP : m_aluop;
        p_alusel = hz ? `EX_RES_NOP : m_alusel;
        hold = hz;
    endtask

    task automatic check_reset_state();
        compare("pc_o", '0, pc_o);
        compare("r1", '0, r1);
        compare("r2", '0, r2);
        compare("imm", '0, imm);
        compare("rd", '0, 32'(rd));
        compare("rd_enable", '0, 32'(rd_enable));
        compare("aluop", 32'(`EX_NOP), 32'(aluop));
        compare("alusel", 32'(`EX_RES_NOP), 32'(alusel));
    endtask

    task automatic step(input int mode, input int ld_pct);
        @(posedge clk);
        drive_inputs(mode, ld_pct);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic finish_test(input int n);
        if (test_errors == 0) begin
            $display("test %s: passed, %0d cycles", cur_test, n);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    task automatic run_test(input string name, input int mode, input int ld_pct);
        cur_test = name;
        test_errors = 0;
        repeat (TEST_CYCLES) begin
            step(mode, ld_pct);
        end
        finish_test(TEST_CYCLES);
    endtask

    initial begin
        seed = 14;
        rst = 1'b1;
        pc = '0;
        inst = '0;
        r1_data = '0;
        r2_data = '0;
        ld_flag = 1'b0;
        ex_wb_flag = 1'b0;
        ex_wb_addr = '0;
        ex_forward = '0;
        mem_wb_flag = 1'b0;
        mem_wb_addr = '0;
        mem_forward = '0;
        hold = 1'b0;
        pred_valid = 1'b0;
        errors = 0;
        tests_failed = 0;
        cur_test = "reset";
        test_errors = 0;
        repeat (RESET_CYCLES) begin
            step(2, 20);
            check_reset_state();
        end
        @(posedge clk);
        rst <= 1'b0;
        drive_inputs(2, 20);
        @(negedge clk);
        check_reset_state();  // Release edge still sees reset
        check_outputs();
        pred_valid = 1'b1;
        finish_test(RESET_CYCLES + 1);
        run_test("alu_decode", 0, 10);
        run_test("mem_ctrl_decode", 1, 10);
        run_test("forwarding", 2, 0);
        run_test("load_use", 2, 50);
        run_test("unknown_opcode", 3, 50);
        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/rv_inst_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/operand_forward.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
tb/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_id_stage -o sim_id_stage \
    && ./obj_dir/sim_id_stage | tee /dev/stderr | grep -qx '\*\* PASS \*\*' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
